/* common/rename_pkg.sv */
package rename_pkg;

    // Architectural register file
    localparam int unsigned ARF_DEPTH = 32;
    localparam int unsigned ARF_ID_W  = 5;

    // Reorder buffer
    localparam int unsigned ROB_DEPTH = 64;
    localparam int unsigned ROB_ID_W  = 6;

    // Register data width
    localparam int unsigned XLEN = 32;

    typedef logic [ARF_ID_W-1:0] arf_id_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Entry of either rename table
    // Speculative and committed check bits differ while a producer is in flight
    typedef struct packed {
        logic    check;
        rob_id_t robid;
    } rat_entry_t;

endpackage

/* hdl/mp_regfile.sv */
`timescale 1ns/1ps

module mp_regfile import rename_pkg::*; #(
    parameter int unsigned  DATA_WIDTH   = XLEN,
    parameter int unsigned  DEPTH        = ARF_DEPTH,
    parameter int unsigned  R_PORTS      = 4,
    parameter int unsigned  W_PORTS      = 2,
    parameter bit           NEED_RESET   = 1'b1,
    parameter bit           NEED_FORWARD = 1'b0,
    localparam int unsigned ADDR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               clear_i,
    input  logic [R_PORTS-1:0][ADDR_W-1:0]     raddr_i,
    output logic [R_PORTS-1:0][DATA_WIDTH-1:0] rdata_o,
    input  logic [W_PORTS-1:0][ADDR_W-1:0]     waddr_i,
    input  logic [W_PORTS-1:0]                 we_i,
    input  logic [W_PORTS-1:0][DATA_WIDTH-1:0] wdata_i
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    generate
        if (NEED_RESET) begin : g_rst
            always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= '0;
                    end
                end else if (clear_i) begin
                    // Clear wins over any write in the same cycle
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= '0;
                    end
                end else begin
                    for (int w = 0; w < W_PORTS; w++) begin
                        if (we_i[w]) begin
                            mem[waddr_i[w]] <= wdata_i[w];  // Higher port wins
                        end
                    end
                end
            end
        end else begin : g_norst
            always_ff @(posedge clk) begin
                for (int w = 0; w < W_PORTS; w++) begin
                    if (we_i[w]) begin
                        mem[waddr_i[w]] <= wdata_i[w];
                    end
                end
            end
        end
    endgenerate

    // Combinational read ports
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
            if (NEED_FORWARD) begin
                // Bypass this cycle's writes, last matching port taken
                for (int w = 0; w < W_PORTS; w++) begin
                    if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
                        rdata_o[r] = wdata_i[w];
                    end
                end
            end
        end
    end

endmodule

/* rename/rob_alloc.sv */
`timescale 1ns/1ps

module rob_alloc import rename_pkg::*; #(
    parameter int unsigned ROB_SLACK = 4
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic [1:0] issue_i,
    input  logic [1:0] retire_i,
    output rob_id_t    alloc_id0_o,
    output rob_id_t    alloc_id1_o,
    output logic       avail_o
);

    // One extra bit so a completely full ROB is representable
    localparam int unsigned      CNT_W     = ROB_ID_W + 1;
    localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(ROB_DEPTH - ROB_SLACK);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic [CNT_W-1:0] n_issue;
    logic [CNT_W-1:0] n_retire;
    rob_id_t          ptr0_q;
    rob_id_t          ptr1_q;
    logic             avail_q;

    assign n_issue  = CNT_W'(issue_i[0]) + CNT_W'(issue_i[1]);
    assign n_retire = CNT_W'(retire_i[0]) + CNT_W'(retire_i[1]);
    assign cnt_d    = cnt_q + n_issue - n_retire;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q   <= '0;
            ptr0_q  <= '0;
            ptr1_q  <= rob_id_t'(ROB_DEPTH - 1);
            avail_q <= 1'b1;
        end else if (flush_i) begin
            cnt_q   <= '0;
            ptr0_q  <= '0;
            ptr1_q  <= rob_id_t'(ROB_DEPTH - 1);
            avail_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            ptr0_q  <= ptr0_q + rob_id_t'(n_issue);  // Wraps mod ROB_DEPTH
            ptr1_q  <= ptr1_q + rob_id_t'(n_issue);
            avail_q <= (cnt_q <= CNT_LIMIT);         // Lags the count by a cycle
        end
    end

    assign alloc_id0_o = ptr0_q;
    assign alloc_id1_o = ptr1_q;
    assign avail_o     = avail_q;

endmodule

/* rename/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          flush_i,
    // Decode side
    input  logic          in_valid_i,
    output logic          in_ready_o,
    input  logic [1:0]    in_slot_valid_i,
    input  arf_id_t [3:0] in_src_arf_i,     // [1:0] slot 0, [3:2] slot 1
    input  arf_id_t [1:0] in_dst_arf_i,
    // Downstream handshake
    output logic          out_valid_o,
    input  logic          out_ready_i,
    // ROB allocation
    input  logic          avail_i,
    input  rob_id_t       alloc_id0_i,
    input  rob_id_t       alloc_id1_i,
    output logic [1:0]    issue_o,
    // Rename results
    output logic [3:0]    out_src_pending_o,
    output rob_id_t [3:0] out_src_robid_o,
    output rob_id_t [1:0] out_dst_robid_o,
    output logic [1:0]    out_dst_check_o,
    // Commit side
    input  logic [1:0]    retire_i,
    input  arf_id_t [1:0] retire_arf_id_i,
    input  rob_id_t [1:0] retire_rob_id_i,
    input  logic [1:0]    retire_check_i,
    input  logic [1:0]    retire_wvalid_i
);

    logic             fire;
    logic [1:0]       issue;
    logic [1:0]       dst_live;
    logic [1:0]       spec_we;
    logic [1:0]       cmt_we;
    rob_id_t [1:0]    alloc_id;
    rat_entry_t [1:0] spec_wdata;
    rat_entry_t [3:0] spec_rdata;
    rat_entry_t [1:0] cmt_wdata;
    rat_entry_t [5:0] cmt_rdata;            // [3:0] sources, [5:4] destinations

    // Handshake
    assign in_ready_o  = avail_i & ~flush_i & out_ready_i;
    assign out_valid_o = in_valid_i & avail_i & ~flush_i;
    assign fire        = in_valid_i & in_ready_o;
    assign issue       = in_slot_valid_i & {2{fire}};
    assign issue_o     = issue;

    assign alloc_id        = {alloc_id1_i, alloc_id0_i};
    assign out_dst_robid_o = alloc_id;

    for (genvar k = 0; k < 2; k++) begin : g_dst
        // x0 is never renamed
        assign dst_live[k] = in_slot_valid_i[k] & (in_dst_arf_i[k] != '0);
        assign spec_we[k]  = dst_live[k] & fire;

        // New mapping flips the committed check bit
        assign spec_wdata[k].check = ~cmt_rdata[4+k].check;
        assign spec_wdata[k].robid = alloc_id[k];
        assign out_dst_check_o[k]  = spec_wdata[k].check;

        // Retire updates the committed mapping
        assign cmt_we[k] = retire_i[k] & retire_wvalid_i[k] & (retire_arf_id_i[k] != '0);
        assign cmt_wdata[k].check = retire_check_i[k];
        assign cmt_wdata[k].robid = retire_rob_id_i[k];
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            out_src_pending_o[i] = spec_rdata[i].check != cmt_rdata[i].check;
            out_src_robid_o[i]   = spec_rdata[i].robid;
            // Slot 1 reading slot 0's destination
            if ((i >= 2) && dst_live[0] && (in_src_arf_i[i] == in_dst_arf_i[0])) begin
                out_src_pending_o[i] = 1'b1;
                out_src_robid_o[i]   = alloc_id0_i;
            end
        end
    end

    // Speculative table, written at issue
    mp_regfile #(
        .DATA_WIDTH   ($bits(rat_entry_t)),
        .DEPTH        (ARF_DEPTH),
        .R_PORTS      (4),
        .W_PORTS      (2),
        .NEED_RESET   (1'b1),
        .NEED_FORWARD (1'b0)
    ) u_spec_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (flush_i),
        .raddr_i  (in_src_arf_i),
        .rdata_o  (spec_rdata),
        .waddr_i  (in_dst_arf_i),
        .we_i     (spec_we),
        .wdata_i  (spec_wdata)
    );

    // Committed table, written at retire
    // Destination ports supply the check bit to flip
    mp_regfile #(
        .DATA_WIDTH   ($bits(rat_entry_t)),
        .DEPTH        (ARF_DEPTH),
        .R_PORTS      (6),
        .W_PORTS      (2),
        .NEED_RESET   (1'b1),
        .NEED_FORWARD (1'b1)
    ) u_cmt_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (flush_i),
        .raddr_i  ({in_dst_arf_i, in_src_arf_i}),
        .rdata_o  (cmt_rdata),
        .waddr_i  (retire_arf_id_i),
        .we_i     (cmt_we),
        .wdata_i  (cmt_wdata)
    );

endmodule

/* hdl/rename_top.sv */
`timescale 1ns/1ps

module rename_top import rename_pkg::*; #(
    parameter int unsigned ROB_SLACK = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    // Decode side
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  logic [1:0]           in_slot_valid_i,
    input  arf_id_t [3:0]        in_src_arf_i,
    input  arf_id_t [1:0]        in_dst_arf_i,
    // Downstream
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output logic [3:0][XLEN-1:0] out_src_data_o,
    output logic [3:0]           out_src_pending_o,
    output rob_id_t [3:0]        out_src_robid_o,
    output rob_id_t [1:0]        out_dst_robid_o,
    output logic [1:0]           out_dst_check_o,
    // Commit side
    input  logic [1:0]           retire_i,
    input  arf_id_t [1:0]        retire_arf_id_i,
    input  rob_id_t [1:0]        retire_rob_id_i,
    input  logic [1:0]           retire_check_i,
    input  logic [1:0]           retire_wvalid_i,
    input  logic [1:0][XLEN-1:0] retire_data_i
);

    logic       avail;
    rob_id_t    alloc_id0;
    rob_id_t    alloc_id1;
    logic [1:0] issue;
    logic [1:0] arf_we;

    // ARF writes skip x0
    assign arf_we[0] = retire_i[0] & retire_wvalid_i[0] & (retire_arf_id_i[0] != '0);
    assign arf_we[1] = retire_i[1] & retire_wvalid_i[1] & (retire_arf_id_i[1] != '0);

    rob_alloc #(
        .ROB_SLACK (ROB_SLACK)
    ) u_rob_alloc (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .issue_i     (issue),
        .retire_i    (retire_i),
        .alloc_id0_o (alloc_id0),
        .alloc_id1_o (alloc_id1),
        .avail_o     (avail)
    );

    rename_stage u_rename_stage (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .flush_i           (flush_i),
        .in_valid_i        (in_valid_i),
        .in_ready_o        (in_ready_o),
        .in_slot_valid_i   (in_slot_valid_i),
        .in_src_arf_i      (in_src_arf_i),
        .in_dst_arf_i      (in_dst_arf_i),
        .out_valid_o       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .avail_i           (avail),
        .alloc_id0_i       (alloc_id0),
        .alloc_id1_i       (alloc_id1),
        .issue_o           (issue),
        .out_src_pending_o (out_src_pending_o),
        .out_src_robid_o   (out_src_robid_o),
        .out_dst_robid_o   (out_dst_robid_o),
        .out_dst_check_o   (out_dst_check_o),
        .retire_i          (retire_i),
        .retire_arf_id_i   (retire_arf_id_i),
        .retire_rob_id_i   (retire_rob_id_i),
        .retire_check_i    (retire_check_i),
        .retire_wvalid_i   (retire_wvalid_i)
    );

    // Architectural register file
    mp_regfile #(
        .DATA_WIDTH   (XLEN),
        .DEPTH        (ARF_DEPTH),
        .R_PORTS      (4),
        .W_PORTS      (2),
        .NEED_RESET   (1'b1),
        .NEED_FORWARD (1'b1)
    ) u_arf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (flush_i),
        .raddr_i  (in_src_arf_i),
        .rdata_o  (out_src_data_o),
        .waddr_i  (retire_arf_id_i),
        .we_i     (arf_we),
        .wdata_i  (retire_data_i)
    );

endmodule

/* tb/rename_props.sv */
`timescale 1ns/1ps

module rename_props import rename_pkg::*; (
    input logic          clk,
    input logic          arst_n_i,
    input logic          flush_i,
    input logic          in_ready_o,
    input logic          out_ready_i,
    input logic [1:0]    issue_o,
    input arf_id_t [3:0] in_src_arf_i,
    input logic [3:0]    out_src_pending_o
);

    a_flush_blocks_ready: assert property (
        @(posedge clk) disable iff (!arst_n_i) flush_i |-> !in_ready_o
    ) else $error("in_ready_o high during flush");

    // Back-pressure stops all allocation
    a_stall_no_issue: assert property (
        @(posedge clk) disable iff (!arst_n_i) !out_ready_i |-> (issue_o == 2'b00)
    ) else $error("issue_o nonzero while out_ready_i low");

    for (genvar i = 0; i < 4; i++) begin : g_x0
        a_x0_not_pending: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            (in_src_arf_i[i] == '0) |-> !out_src_pending_o[i]
        ) else $error("x0 source reported pending");
    end

endmodule

bind rename_stage rename_props u_props (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush_i),
    .in_ready_o        (in_ready_o),
    .out_ready_i       (out_ready_i),
    .issue_o           (issue_o),
    .in_src_arf_i      (in_src_arf_i),
    .out_src_pending_o (out_src_pending_o)
);

/* tb/rename_tb.sv */
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    localparam int SLACK = 4;

    logic                 clk;
    logic                 arst_n;
    logic                 flush;
    logic                 in_valid;
    logic                 in_ready;
    logic [1:0]           slot_valid;
    arf_id_t [3:0]        src;
    arf_id_t [1:0]        dst;
    logic                 out_valid;
    logic                 out_ready;
    logic [3:0][XLEN-1:0] src_data;
    logic [3:0]           src_pending;
    rob_id_t [3:0]        src_robid;
    rob_id_t [1:0]        dst_robid;
    logic [1:0]           dst_check;
    logic [1:0]           retire;
    arf_id_t [1:0]        ret_id;
    rob_id_t [1:0]        ret_rob;
    logic [1:0]           ret_check;
    logic [1:0]           ret_wvalid;
    logic [1:0][XLEN-1:0] ret_data;

    // Reference model state
    logic            m_spec_chk [ARF_DEPTH];
    rob_id_t         m_spec_rob [ARF_DEPTH];
    logic            m_cmt_chk  [ARF_DEPTH];
    logic [XLEN-1:0] m_arf      [ARF_DEPTH];
    rob_id_t         m_ptr0;
    rob_id_t         m_ptr1;
    int              m_cnt;
    logic            m_avail;
    logic [31:0]     rng;

    rename_top #(
        .ROB_SLACK (SLACK)
    ) u_dut (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .flush_i           (flush),
        .in_valid_i        (in_valid),
        .in_ready_o        (in_ready),
        .in_slot_valid_i   (slot_valid),
        .in_src_arf_i      (src),
        .in_dst_arf_i      (dst),
        .out_valid_o       (out_valid),
        .out_ready_i       (out_ready),
        .out_src_data_o    (src_data),
        .out_src_pending_o (src_pending),
        .out_src_robid_o   (src_robid),
        .out_dst_robid_o   (dst_robid),
        .out_dst_check_o   (dst_check),
        .retire_i          (retire),
        .retire_arf_id_i   (ret_id),
        .retire_rob_id_i   (ret_rob),
        .retire_check_i    (ret_check),
        .retire_wvalid_i   (ret_wvalid),
        .retire_data_i     (ret_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Retire port k writes a register this cycle
    function automatic logic retire_writes(input int k);
        return retire[k] && ret_wvalid[k] && (ret_id[k] != '0);
    endfunction

    function automatic logic cmt_check_now(input arf_id_t id);
        logic c;
        c = m_cmt_chk[id];
        for (int k = 0; k < 2; k++) begin
            if (retire_writes(k) && (ret_id[k] == id)) c = ret_check[k];  // Port 1 wins
        end
        return c;
    endfunction

    function automatic logic [XLEN-1:0] arf_now(input arf_id_t id);
        logic [XLEN-1:0] v;
        v = m_arf[id];
        for (int k = 0; k < 2; k++) begin
            if (retire_writes(k) && (ret_id[k] == id)) v = ret_data[k];
        end
        return v;
    endfunction

    task automatic clear_model();
        for (int r = 0; r < ARF_DEPTH; r++) begin
            m_spec_chk[r] = 1'b0;
            m_spec_rob[r] = '0;
            m_cmt_chk[r]  = 1'b0;
            m_arf[r]      = '0;
        end
        m_ptr0  = '0;
        m_ptr1  = rob_id_t'(ROB_DEPTH - 1);
        m_cnt   = 0;
        m_avail = 1'b1;
    endtask

    task automatic idle();
        in_valid   = 1'b0;
        slot_valid = '0;
        src        = '0;
        dst        = '0;
        retire     = '0;
        ret_id     = '0;
        ret_rob    = '0;
        ret_check  = '0;
        ret_wvalid = '0;
        ret_data   = '0;
    endtask

    task automatic drive_bundle(input logic [1:0] sv, input arf_id_t [3:0] s,
                                input arf_id_t [1:0] d);
        in_valid   = 1'b1;
        slot_valid = sv;
        src        = s;
        dst        = d;
    endtask

    task automatic drive_retire(input int k, input arf_id_t id, input rob_id_t rob,
                                input logic chk, input logic [XLEN-1:0] data);
        retire[k]     = 1'b1;
        ret_wvalid[k] = 1'b1;
        ret_id[k]     = id;
        ret_rob[k]    = rob;
        ret_check[k]  = chk;
        ret_data[k]   = data;
    endtask

    // Compare all outputs with the model for the inputs now driven
    task automatic expect_outputs();
        logic    vld;
        logic    pend;
        rob_id_t rid;
        #2;
        vld = in_valid && m_avail && !flush;
        check_val("in_ready_o", in_ready, m_avail && !flush && out_ready);
        check_val("out_valid_o", out_valid, vld);
        if (vld) begin
            for (int i = 0; i < 4; i++) begin
                pend = m_spec_chk[src[i]] != cmt_check_now(src[i]);
                rid  = m_spec_rob[src[i]];
                if ((i >= 2) && slot_valid[0] && (dst[0] != '0) && (src[i] == dst[0])) begin
                    pend = 1'b1;  // Bypass from slot 0
                    rid  = m_ptr0;
                end
                check_val($sformatf("out_src_pending_o[%0d]", i), src_pending[i], pend);
                if (pend) check_val($sformatf("out_src_robid_o[%0d]", i), src_robid[i], rid);
                else check_val($sformatf("out_src_data_o[%0d]", i), src_data[i], arf_now(src[i]));
            end
            check_val("out_dst_robid_o[0]", dst_robid[0], m_ptr0);
            check_val("out_dst_robid_o[1]", dst_robid[1], m_ptr1);
            for (int k = 0; k < 2; k++) begin
                if (slot_valid[k]) begin
                    check_val($sformatf("out_dst_check_o[%0d]", k), dst_check[k],
                              !cmt_check_now(dst[k]));
                end
            end
        end
    endtask

    // Advance one cycle and apply the same edge to the model
    task automatic clock_edge();
        logic       fire;
        logic [1:0] iss;
        logic [1:0] new_chk;
        int         n_iss;
        @(posedge clk);
        fire  = in_valid && m_avail && !flush && out_ready;
        iss   = slot_valid & {2{fire}};
        n_iss = int'(iss[0]) + int'(iss[1]);
        if (flush) begin
            clear_model();
        end else begin
            for (int k = 0; k < 2; k++) new_chk[k] = !cmt_check_now(dst[k]);
            for (int k = 0; k < 2; k++) begin
                if (iss[k] && (dst[k] != '0)) begin
                    m_spec_chk[dst[k]] = new_chk[k];
                    m_spec_rob[dst[k]] = (k == 0) ? m_ptr0 : m_ptr1;
                end
                if (retire_writes(k)) begin
                    m_cmt_chk[ret_id[k]] = ret_check[k];
                    m_arf[ret_id[k]]     = ret_data[k];
                end
            end
            m_avail = (m_cnt <= ROB_DEPTH - SLACK);  // From the old count
            m_cnt   = m_cnt + n_iss - int'(retire[0]) - int'(retire[1]);
            m_ptr0  = m_ptr0 + rob_id_t'(n_iss);
            m_ptr1  = m_ptr1 + rob_id_t'(n_iss);
        end
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        drive_bundle(2'b11, {5'd4, 5'd3, 5'd2, 5'd1}, {5'd6, 5'd5});
        expect_outputs();
        for (int i = 0; i < 4; i++) begin
            check_val($sformatf("out_src_pending_o[%0d]", i), src_pending[i], 1'b0);
            check_val($sformatf("out_src_data_o[%0d]", i), src_data[i], '0);
        end
        check_val("out_dst_robid_o[0]", dst_robid[0], 0);
        check_val("out_dst_robid_o[1]", dst_robid[1], ROB_DEPTH - 1);
        clock_edge();
        idle();
    endtask

    task automatic test_read_after_write();
        rob_id_t wid;
        wid = m_ptr0;
        drive_bundle(2'b01, '0, {5'd0, 5'd7});
        expect_outputs();
        check_val("out_dst_check_o[0]", dst_check[0], !m_cmt_chk[7]);
        clock_edge();
        drive_bundle(2'b11, {5'd2, 5'd7, 5'd1, 5'd7}, {5'd9, 5'd8});
        expect_outputs();
        check_val("out_src_pending_o[0]", src_pending[0], 1'b1);
        check_val("out_src_robid_o[0]", src_robid[0], wid);
        clock_edge();
        idle();
    endtask

    task automatic test_bundle_bypass();
        drive_bundle(2'b11, {5'd0, 5'd12, 5'd2, 5'd1}, {5'd13, 5'd12});
        expect_outputs();
        check_val("out_src_pending_o[2]", src_pending[2], 1'b1);
        check_val("out_src_robid_o[2]", src_robid[2], m_ptr0);
        check_val("out_src_pending_o[3]", src_pending[3], 1'b0);
        clock_edge();
        idle();
    endtask

    task automatic test_retire_writers();
        rob_id_t         old_id;
        rob_id_t         new_id;
        logic            old_chk;
        logic            new_chk;
        logic [XLEN-1:0] old_data;
        logic [XLEN-1:0] new_data;
        rng      = xorshift(rng);
        old_data = rng;
        rng      = xorshift(rng);
        new_data = rng;
        // Older writer of r10
        old_id  = m_ptr0;
        old_chk = !m_cmt_chk[10];
        drive_bundle(2'b01, '0, {5'd0, 5'd10});
        expect_outputs();
        clock_edge();
        idle();
        // Newest writer of r10 issues while the older one retires
        new_id  = m_ptr0;
        new_chk = !old_chk;
        drive_retire(0, 5'd10, old_id, old_chk, old_data);
        drive_bundle(2'b01, {5'd0, 5'd0, 5'd0, 5'd10}, {5'd0, 5'd10});
        expect_outputs();
        check_val("out_src_data_o[0]", src_data[0], old_data);
        check_val("out_dst_check_o[0]", dst_check[0], new_chk);
        clock_edge();
        idle();
        drive_bundle(2'b00, {5'd0, 5'd0, 5'd0, 5'd10}, '0);
        expect_outputs();
        check_val("out_src_pending_o[0]", src_pending[0], 1'b1);  // Newest still in flight
        check_val("out_src_robid_o[0]", src_robid[0], new_id);
        clock_edge();
        idle();
        drive_retire(0, 5'd10, new_id, new_chk, new_data);
        clock_edge();
        idle();
        drive_bundle(2'b00, {5'd0, 5'd0, 5'd0, 5'd10}, '0);
        expect_outputs();
        check_val("out_src_pending_o[0]", src_pending[0], 1'b0);
        check_val("out_src_data_o[0]", src_data[0], new_data);
        clock_edge();
        idle();
    endtask

    task automatic test_rob_backpressure();
        int      waited;
        rob_id_t held;
        waited = 0;
        rng = xorshift(rng);
        drive_bundle(2'b11, rng[19:0], rng[29:20]);
        expect_outputs();
        while (in_ready) begin
            clock_edge();
            waited++;
            if (waited > 64) fail_run("in_ready_o stayed high while the ROB filled up");
            rng = xorshift(rng);
            drive_bundle(2'b11, rng[19:0], rng[29:20]);
            expect_outputs();
        end
        idle();
        retire = 2'b11;  // Free entries without register writes
        expect_outputs();
        waited = 0;
        while (!in_ready) begin
            clock_edge();
            waited++;
            if (waited > 8) fail_run("in_ready_o did not return after retiring");
            expect_outputs();
        end
        idle();
        out_ready = 1'b0;
        held      = m_ptr0;
        // Sources read back the stalled destinations
        drive_bundle(2'b11, {5'd0, 5'd0, 5'd16, 5'd15}, {5'd16, 5'd15});
        expect_outputs();
        check_val("issue_o", u_dut.u_rename_stage.issue_o, 2'b00);
        clock_edge();
        out_ready = 1'b1;
        expect_outputs();
        check_val("out_dst_robid_o[0]", dst_robid[0], held);
        clock_edge();
        idle();
    endtask

    task automatic test_flush();
        drive_bundle(2'b11, {5'd12, 5'd7, 5'd14, 5'd10}, {5'd18, 5'd17});
        flush = 1'b1;
        expect_outputs();
        clock_edge();
        flush = 1'b0;
        expect_outputs();
        for (int i = 0; i < 4; i++) begin
            check_val($sformatf("out_src_pending_o[%0d]", i), src_pending[i], 1'b0);
            check_val($sformatf("out_src_data_o[%0d]", i), src_data[i], '0);
        end
        check_val("out_dst_robid_o[0]", dst_robid[0], 0);
        check_val("out_dst_robid_o[1]", dst_robid[1], ROB_DEPTH - 1);
        clock_edge();
        idle();
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        out_ready = 1'b1;
        rng       = 32'd76259;
        idle();
        clear_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_read_after_write();
        test_bundle_bypass();
        test_retire_writers();
        test_rob_backpressure();
        test_flush();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* rename_unit.f */
common/rename_pkg.sv
hdl/mp_regfile.sv
rename/rob_alloc.sv
rename/rename_stage.sv
hdl/rename_top.sv
tb/rename_props.sv
tb/rename_tb.sv

/* Makefile */
TOP   = rename_tb
FLIST = rename_unit.f
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
